//--- source/tgt_pkg.sv
package tgt_pkg;

    // ========================================
    // Bus and field widths
    // ========================================

    // Fixed 4 DW data path
    localparam int DATA_W      = 128;
    localparam int DW_PER_BEAT = 4;

    // Command fields
    localparam int LEN_W    = 10;
    localparam int OFFSET_W = 9;
    localparam int ADDR_W   = 64;
    localparam int ID_W     = 16;
    localparam int TAG_W    = 8;
    localparam int HDR_W    = 128;

    // Zero fill above each header view
    localparam int REQ_FILL_W = HDR_W - (2 + 5 + LEN_W + ID_W + TAG_W + ADDR_W);
    localparam int CPL_FILL_W = HDR_W - (2 + 5 + LEN_W + ID_W + TAG_W + ID_W + 3 + 12);

    // ========================================
    // Encodings
    // ========================================

    // Agent state machine codes that allow puts
    localparam logic [2:0] ISM_IDLE_REQ = 3'b001;
    localparam logic [2:0] ISM_ACTIVE   = 3'b011;

    // Format bit positions
    localparam int FMT_64_BIT       = 0;
    localparam int FMT_HAS_DATA_BIT = 1;

    // Completion type code
    localparam logic [4:0] TYPE_CPL = 5'b01010;

    // Command class seen by the queues
    typedef enum logic [1:0] {
        CLASS_MEM32 = 2'd0,
        CLASS_MEM64 = 2'd1,
        CLASS_CPL   = 2'd2
    } cmd_class_e;

    // ========================================
    // Queue header word
    // ========================================

    // Same 128 bits, read as a request or as a completion
    typedef union packed {
        struct packed {
            logic [REQ_FILL_W-1:0] rsvd;
            logic [1:0]            fmt;
            logic [4:0]            ttype;
            logic [LEN_W-1:0]      length;
            logic [ID_W-1:0]       rqid;
            logic [TAG_W-1:0]      tag;
            // Upper half stays zero for 32-bit addressing
            logic [ADDR_W-1:0]     address;
        } req;
        struct packed {
            logic [CPL_FILL_W-1:0] rsvd;
            logic [1:0]            fmt;
            logic [4:0]            ttype;
            logic [LEN_W-1:0]      length;
            logic [ID_W-1:0]       cplid;
            logic [TAG_W-1:0]      tag;
            logic [ID_W-1:0]       rqid;
            logic [2:0]            status;
            logic [11:0]           byte_count;
        } cpl;
    } tgt_hdr_u;

endpackage

//--- source/tgt_cmd_if.sv
`timescale 1ns/1ps

interface tgt_cmd_if import tgt_pkg::*; ();

    // One pulse per accepted command
    logic             cmd_valid;
    // Flow class from cmd_rtype
    logic [1:0]       cmd_fc;
    tgt_hdr_u         cmd_hdr;
    cmd_class_e       cmd_class;
    logic             cmd_par_err;
    // Data phase follows this command
    logic             cmd_has_data;
    logic [LEN_W-1:0] cmd_length;

    // Header stage drives the command
    modport decode (
        output cmd_valid, cmd_fc, cmd_hdr, cmd_class, cmd_par_err,
        output cmd_has_data, cmd_length
    );

    // Data tracker only needs the length and flow class
    modport track (input cmd_valid, cmd_has_data, cmd_length, cmd_fc);

    // Queue stage takes the full command
    modport push (
        input cmd_valid, cmd_fc, cmd_hdr, cmd_class, cmd_par_err,
        input cmd_has_data, cmd_length
    );

endinterface

//--- source/tgt_data_if.sv
`timescale 1ns/1ps

interface tgt_data_if import tgt_pkg::*; ();

    // One pulse per data beat
    logic                beat_valid;
    logic [DATA_W-1:0]   beat_data;
    logic [1:0]          beat_fc;
    // Beat index within the command
    logic [OFFSET_W-1:0] beat_offset;
    logic                beat_par_err;
    // Beats still owed by the fabric
    logic                busy;

    // Data tracker side
    modport producer (
        output beat_valid, beat_data, beat_fc, beat_offset, beat_par_err, busy
    );

    // Queue stage side
    modport consumer (
        input beat_valid, beat_data, beat_fc, beat_offset, beat_par_err, busy
    );

endinterface

//--- source/tgt_hdr_decode.sv
`timescale 1ns/1ps

module tgt_hdr_decode import tgt_pkg::*; (
    input  logic              prim_nonflr_clk,
    input  logic              prim_gated_rst_b,

    // Fabric command put
    input  logic              cmd_put,
    input  logic [1:0]        cmd_rtype,
    input  logic [1:0]        cmd_fmt,
    input  logic [4:0]        cmd_type,
    input  logic [LEN_W-1:0]  cmd_length,
    input  logic [ID_W-1:0]   cmd_rqid,
    input  logic [TAG_W-1:0]  cmd_tag,
    input  logic [ADDR_W-1:0] cmd_address,
    input  logic              cmd_parity,
    input  logic [2:0]        ism_state,

    // Decoded command to later stages
    tgt_cmd_if.decode         cmd_bus
);

    logic       accept;
    cmd_class_e class_d;
    tgt_hdr_u   hdr_d;
    logic       par_err_d;

    // ========================================
    // Accept, classify and format
    // ========================================

    always_comb begin
        // Puts only count while the agent is up
        accept = cmd_put && ((ism_state == ISM_ACTIVE) || (ism_state == ISM_IDLE_REQ));

        hdr_d = '0;

        if (cmd_type == TYPE_CPL) begin
            class_d = CLASS_CPL;

            // Completion view
            hdr_d.cpl.fmt        = cmd_fmt;
            hdr_d.cpl.ttype      = cmd_type;
            hdr_d.cpl.length     = cmd_length;
            hdr_d.cpl.tag        = cmd_tag;
            // Completer id rides on the rqid field
            hdr_d.cpl.cplid      = cmd_rqid;
            // Requester id, status and byte count are packed in the low address
            hdr_d.cpl.rqid       = cmd_address[31:16];
            hdr_d.cpl.status     = cmd_address[15:13];
            hdr_d.cpl.byte_count = cmd_address[11:0];
        end else begin
            // Memory request, width picked by the format bit
            if (cmd_fmt[FMT_64_BIT]) begin
                class_d = CLASS_MEM64;
            end else begin
                class_d = CLASS_MEM32;
            end

            // Request view
            hdr_d.req.fmt    = cmd_fmt;
            hdr_d.req.ttype  = cmd_type;
            hdr_d.req.length = cmd_length;
            hdr_d.req.rqid   = cmd_rqid;
            hdr_d.req.tag    = cmd_tag;

            // Upper address is dropped for 32-bit requests
            if (cmd_fmt[FMT_64_BIT]) begin
                hdr_d.req.address = cmd_address;
            end else begin
                hdr_d.req.address = {32'h0, cmd_address[31:0]};
            end
        end

        // Even parity across every command field, rtype included
        par_err_d = ^{cmd_rtype, cmd_fmt, cmd_type, cmd_length, cmd_rqid,
                      cmd_tag, cmd_address, cmd_parity};
    end

    // ========================================
    // Command register
    // ========================================

    // Valid pulse for each accepted put
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            cmd_bus.cmd_valid <= 1'b0;
        end else begin
            cmd_bus.cmd_valid <= accept;
        end
    end

    // Payload only loads on an accepted put
    always_ff @(posedge prim_nonflr_clk) begin
        if (accept) begin
            cmd_bus.cmd_fc       <= cmd_rtype;
            cmd_bus.cmd_hdr      <= hdr_d;
            cmd_bus.cmd_class    <= class_d;
            cmd_bus.cmd_par_err  <= par_err_d;
            cmd_bus.cmd_has_data <= cmd_fmt[FMT_HAS_DATA_BIT];
            cmd_bus.cmd_length   <= cmd_length;
        end
    end

endmodule

//--- source/tgt_data_track.sv
`timescale 1ns/1ps

module tgt_data_track import tgt_pkg::*; (
    input  logic              prim_nonflr_clk,
    input  logic              prim_gated_rst_b,

    // Fabric data bus
    input  logic [DATA_W-1:0] data,
    input  logic              data_parity,

    // Command from the header stage
    tgt_cmd_if.track          cmd_bus,

    // Checked beats to the queue stage
    tgt_data_if.producer      data_bus
);

    logic                load;
    logic                take;
    logic                beat_par_err_d;
    logic [LEN_W-1:0]    count_ff;
    logic [LEN_W-1:0]    count_cur;
    logic [LEN_W-1:0]    count_nxt;
    logic [OFFSET_W-1:0] offset_ff;
    logic [OFFSET_W-1:0] offset_cur;
    logic [1:0]          fc_ff;
    logic [1:0]          fc_cur;

    // ========================================
    // Beat counting
    // ========================================

    always_comb begin
        // First beat shows up in the same cycle as cmd_valid
        load = cmd_bus.cmd_valid && cmd_bus.cmd_has_data;

        // A new command overrides the finished one
        if (load) begin
            count_cur  = cmd_bus.cmd_length;
            offset_cur = '0;
            fc_cur     = cmd_bus.cmd_fc;
        end else begin
            count_cur  = count_ff;
            offset_cur = offset_ff;
            fc_cur     = fc_ff;
        end

        // Any DW left means this cycle carries a beat
        take = |count_cur;

        // Four DW per beat, short last beat floors at zero
        if (count_cur > LEN_W'(DW_PER_BEAT)) begin
            count_nxt = count_cur - LEN_W'(DW_PER_BEAT);
        end else begin
            count_nxt = '0;
        end

        // Parity over the whole word
        beat_par_err_d = take && ((^data) ^ data_parity);
    end

    // Beats still owed, including the one on the bus now
    assign data_bus.busy = |count_cur;

    // ========================================
    // Tracking state
    // ========================================

    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            count_ff              <= '0;
            offset_ff             <= '0;
            fc_ff                 <= '0;
            data_bus.beat_valid   <= 1'b0;
            data_bus.beat_par_err <= 1'b0;
        end else begin
            count_ff              <= count_nxt;
            fc_ff                 <= fc_cur;
            data_bus.beat_valid   <= take;
            data_bus.beat_par_err <= beat_par_err_d;

            // Offset steps one per beat
            if (take) begin
                offset_ff <= offset_cur + OFFSET_W'(1);
            end
        end
    end

    // ========================================
    // Beat register
    // ========================================

    // Payload held only when a beat is taken
    always_ff @(posedge prim_nonflr_clk) begin
        if (take) begin
            data_bus.beat_data   <= data;
            data_bus.beat_offset <= offset_cur;
            data_bus.beat_fc     <= fc_cur;
        end
    end

endmodule

//--- source/tgt_queue_push.sv
`timescale 1ns/1ps

module tgt_queue_push import tgt_pkg::*; (
    input  logic                prim_nonflr_clk,
    input  logic                prim_gated_rst_b,

    input  logic                cmd_put,
    input  logic                credit_init_in_progress,

    // Stage inputs
    tgt_cmd_if.push             cmd_bus,
    tgt_data_if.consumer        data_bus,

    // Queue command push
    output logic                push_cmd,
    output logic [1:0]          cmd_fc,
    output tgt_hdr_u            cmd_hdr,
    output cmd_class_e          cmd_class,
    output logic                cpar_err,

    // Queue data push
    output logic                push_data,
    output logic [DATA_W-1:0]   data_out,
    output logic [1:0]          data_fc,
    output logic [OFFSET_W-1:0] data_ptr_offset,
    output logic                dpar_err,

    output logic                tgt_idle
);

    // ========================================
    // Output register stage
    // ========================================

    // Push strobes and error flags
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            push_cmd  <= 1'b0;
            cpar_err  <= 1'b0;
            push_data <= 1'b0;
            dpar_err  <= 1'b0;
        end else begin
            push_cmd  <= cmd_bus.cmd_valid;
            cpar_err  <= cmd_bus.cmd_valid && cmd_bus.cmd_par_err;
            push_data <= data_bus.beat_valid;
            dpar_err  <= data_bus.beat_valid && data_bus.beat_par_err;
        end
    end

    // Payload reads as zero between pushes
    always_ff @(posedge prim_nonflr_clk) begin
        cmd_fc          <= cmd_bus.cmd_valid ? cmd_bus.cmd_fc : 2'b00;
        cmd_hdr         <= cmd_bus.cmd_valid ? cmd_bus.cmd_hdr : '0;
        cmd_class       <= cmd_bus.cmd_valid ? cmd_bus.cmd_class : CLASS_MEM32;
        data_out        <= data_bus.beat_valid ? data_bus.beat_data : '0;
        data_fc         <= data_bus.beat_valid ? data_bus.beat_fc : 2'b00;
        data_ptr_offset <= data_bus.beat_valid ? data_bus.beat_offset : '0;
    end

    // ========================================
    // Idle
    // ========================================

    // Nothing arriving, nothing owed, nothing in flight in any stage
    assign tgt_idle = !credit_init_in_progress && !cmd_put &&
                      !cmd_bus.cmd_valid && !data_bus.busy && !data_bus.beat_valid &&
                      !push_cmd && !push_data;

endmodule

//--- source/tgt_cntrl_top.sv
`timescale 1ns/1ps

module tgt_cntrl_top import tgt_pkg::*; (
    input  logic                prim_nonflr_clk,
    input  logic                prim_gated_rst_b,

    // Fabric command put
    input  logic                cmd_put,
    input  logic [1:0]          cmd_rtype,
    input  logic [1:0]          cmd_fmt,
    input  logic [4:0]          cmd_type,
    input  logic [LEN_W-1:0]    cmd_length,
    input  logic [ID_W-1:0]     cmd_rqid,
    input  logic [TAG_W-1:0]    cmd_tag,
    input  logic [ADDR_W-1:0]   cmd_address,
    input  logic                cmd_parity,
    input  logic [2:0]          ism_state,

    // Fabric data
    input  logic [DATA_W-1:0]   data,
    input  logic                data_parity,

    input  logic                credit_init_in_progress,

    // Queue command push
    output logic                push_cmd,
    output logic [1:0]          cmd_fc,
    output tgt_hdr_u            cmd_hdr,
    output cmd_class_e          cmd_class,
    output logic                cpar_err,

    // Queue data push
    output logic                push_data,
    output logic [DATA_W-1:0]   data_out,
    output logic [1:0]          data_fc,
    output logic [OFFSET_W-1:0] data_ptr_offset,
    output logic                dpar_err,

    output logic                tgt_idle
);

    // Stage links
    tgt_cmd_if  cmd_bus ();
    tgt_data_if data_bus ();

    // Stage 1, command decode
    tgt_hdr_decode hdr_decode_inst (
        .prim_nonflr_clk  (prim_nonflr_clk),
        .prim_gated_rst_b (prim_gated_rst_b),
        .cmd_put          (cmd_put),
        .cmd_rtype        (cmd_rtype),
        .cmd_fmt          (cmd_fmt),
        .cmd_type         (cmd_type),
        .cmd_length       (cmd_length),
        .cmd_rqid         (cmd_rqid),
        .cmd_tag          (cmd_tag),
        .cmd_address      (cmd_address),
        .cmd_parity       (cmd_parity),
        .ism_state        (ism_state),
        .cmd_bus          (cmd_bus)
    );

    // Stage 2, data phase
    tgt_data_track data_track_inst (
        .prim_nonflr_clk  (prim_nonflr_clk),
        .prim_gated_rst_b (prim_gated_rst_b),
        .data             (data),
        .data_parity      (data_parity),
        .cmd_bus          (cmd_bus),
        .data_bus         (data_bus)
    );

    // Stage 3, queue output register
    tgt_queue_push queue_push_inst (
        .prim_nonflr_clk         (prim_nonflr_clk),
        .prim_gated_rst_b        (prim_gated_rst_b),
        .cmd_put                 (cmd_put),
        .credit_init_in_progress (credit_init_in_progress),
        .cmd_bus                 (cmd_bus),
        .data_bus                (data_bus),
        .push_cmd                (push_cmd),
        .cmd_fc                  (cmd_fc),
        .cmd_hdr                 (cmd_hdr),
        .cmd_class               (cmd_class),
        .cpar_err                (cpar_err),
        .push_data               (push_data),
        .data_out                (data_out),
        .data_fc                 (data_fc),
        .data_ptr_offset         (data_ptr_offset),
        .dpar_err                (dpar_err),
        .tgt_idle                (tgt_idle)
    );

endmodule

//--- verif/tb_tgt_cntrl.sv
`timescale 1ns/1ps

module tb_tgt_cntrl import tgt_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int N_HDR_CMDS = 36;
    localparam int N_GATED    = 6;
    localparam int N_CHAIN    = 8;
    localparam int MAX_BEATS  = 16;
    // Worst case per command is a put, 16 beats and a gap cycle
    localparam int WATCHDOG_CYCLES =
        2 * ((N_HDR_CMDS + 64 + N_GATED + 2 * N_CHAIN + 3) * (MAX_BEATS + 2) + 40);

    typedef struct packed {
        int               due;
        logic [HDR_W-1:0] hdr;
        cmd_class_e       cls;
        logic [1:0]       fc;
        logic             par_err;
    } exp_cmd_t;

    typedef struct packed {
        int                  due;
        logic [DATA_W-1:0]   data;
        logic [1:0]          fc;
        logic [OFFSET_W-1:0] offset;
        logic                par_err;
    } exp_data_t;

    logic prim_nonflr_clk;
    logic prim_gated_rst_b;
    logic cmd_put, cmd_parity, data_parity, credit_init_in_progress;
    logic [1:0] cmd_rtype, cmd_fmt;
    logic [4:0] cmd_type;
    logic [LEN_W-1:0] cmd_length;
    logic [ID_W-1:0] cmd_rqid;
    logic [TAG_W-1:0] cmd_tag;
    logic [ADDR_W-1:0] cmd_address;
    logic [2:0] ism_state;
    logic [DATA_W-1:0] data;
    logic push_cmd, cpar_err, push_data, dpar_err, tgt_idle;
    logic [1:0] cmd_fc, data_fc;
    tgt_hdr_u cmd_hdr;
    cmd_class_e cmd_class;
    logic [DATA_W-1:0] data_out;
    logic [OFFSET_W-1:0] data_ptr_offset;

    // Expected pushes of the reference model in due order
    exp_cmd_t  cmd_q[$];
    exp_data_t data_q[$];
    int cyc;
    logic exp_push_cmd, exp_cpar, exp_push_data, exp_dpar, exp_pending;
    logic [HDR_W-1:0] exp_hdr;
    cmd_class_e exp_class;
    logic [1:0] exp_fc, exp_data_fc;
    logic [DATA_W-1:0] exp_data;
    logic [OFFSET_W-1:0] exp_offset;

    // Beat bookkeeping for the command in its data phase
    int beat_idx;
    logic [1:0] beat_fc;
    bit owed_beat;
    bit owed_bad;
    int issued_cmds, issued_beats, seen_cmds, seen_beats;
    int value_errs, other_errs;

    tgt_cntrl_top tgt_cntrl_top_inst (.*);

    initial begin
        prim_nonflr_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) prim_nonflr_clk = ~prim_nonflr_clk;
        end
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] want);
        value_errs++;
        $display("Error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
    endtask

    // Drives one put and queues its expected command push
    task automatic put_cmd(input logic [1:0] fmt, input logic [4:0] ctype, input int len,
                           input bit bad_par, input bit gated);
        logic [1:0]        rtype;
        logic [ID_W-1:0]   rqid;
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len_f;
        logic [2:0]        state;
        exp_cmd_t          ent;
        rtype = 2'($urandom());
        rqid  = 16'($urandom());
        tag   = 8'($urandom());
        addr  = {$urandom(), $urandom()};
        len_f = LEN_W'(len);
        if (gated) begin
            // Any agent state that blocks puts
            state = 3'($urandom());
            while (state == ISM_ACTIVE || state == ISM_IDLE_REQ) begin
                state = 3'($urandom());
            end
        end else begin
            state = ($urandom() % 2 == 0) ? ISM_ACTIVE : ISM_IDLE_REQ;
        end
        cmd_put     <= 1'b1;
        cmd_rtype   <= rtype;
        cmd_fmt     <= fmt;
        cmd_type    <= ctype;
        cmd_length  <= len_f;
        cmd_rqid    <= rqid;
        cmd_tag     <= tag;
        cmd_address <= addr;
        ism_state   <= state;
        // Even parity that is flipped on request
        cmd_parity  <= (^{rtype, fmt, ctype, len_f, rqid, tag, addr}) ^ bad_par;
        if (!gated) begin
            ent.due     = cyc + 2;
            ent.fc      = rtype;
            ent.par_err = bad_par;
            if (ctype == TYPE_CPL) begin
                ent.cls = CLASS_CPL;
                // Fill, fmt, type, len, cpl id, tag, rq id, status, byte count
                ent.hdr = {56'h0, fmt, ctype, len_f, rqid, tag,
                           addr[31:16], addr[15:13], addr[11:0]};
            end else if (fmt[FMT_64_BIT]) begin
                ent.cls = CLASS_MEM64;
                ent.hdr = {23'h0, fmt, ctype, len_f, rqid, tag, addr};
            end else begin
                ent.cls = CLASS_MEM32;
                ent.hdr = {23'h0, fmt, ctype, len_f, rqid, tag, 32'h0, addr[31:0]};
            end
            cmd_q.push_back(ent);
            issued_cmds++;
        end
        beat_idx = 0;
        beat_fc  = rtype;
    endtask

    task automatic drive_beat(input bit bad_par);
        logic [DATA_W-1:0] word;
        exp_data_t         ent;
        word = {$urandom(), $urandom(), $urandom(), $urandom()};
        data        <= word;
        data_parity <= (^word) ^ bad_par;
        ent.due     = cyc + 2;
        ent.data    = word;
        ent.fc      = beat_fc;
        ent.offset  = OFFSET_W'(beat_idx);
        ent.par_err = bad_par;
        data_q.push_back(ent);
        beat_idx++;
        issued_beats++;
    endtask

    // Put plus data phase
    // Chain leaves the last beat for the next put's cycle
    task automatic run_cmd(input int kind, input bit with_data, input int len,
                           input bit bad_cpar, input int bad_beat, input bit gated,
                           input bit chain);
        logic [1:0] fmt;
        logic [4:0] ctype;
        int         nb;
        int         i;
        fmt[FMT_HAS_DATA_BIT] = with_data;
        fmt[FMT_64_BIT] = (kind == 1) ? 1'b1 : ((kind == 2) ? 1'($urandom()) : 1'b0);
        ctype = (kind == 2) ? TYPE_CPL : 5'($urandom());
        if (kind != 2 && ctype == TYPE_CPL) begin
            ctype = 5'b00000;
        end
        nb = (with_data && !gated) ? (len + 3) / 4 : 0;
        @(posedge prim_nonflr_clk);
        if (owed_beat) begin
            drive_beat(owed_bad);
            owed_beat = 1'b0;
        end
        put_cmd(fmt, ctype, len, bad_cpar, gated);
        for (i = 0; i < nb; i++) begin
            if (chain && i == nb - 1) begin
                owed_beat = 1'b1;
                owed_bad  = (i == bad_beat);
                return;
            end
            @(posedge prim_nonflr_clk);
            cmd_put <= 1'b0;
            drive_beat(i == bad_beat);
        end
        @(posedge prim_nonflr_clk);
        cmd_put <= 1'b0;
    endtask

    // ========================================
    // Reference model and checks
    // ========================================

    // Pops each expected push in the cycle the DUT registers it
    always @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin : model_outputs
        exp_cmd_t  ce;
        exp_data_t de;
        if (!prim_gated_rst_b) begin
            cyc           <= 0;
            exp_push_cmd  <= 1'b0;
            exp_cpar      <= 1'b0;
            exp_push_data <= 1'b0;
            exp_dpar      <= 1'b0;
            exp_pending   <= 1'b0;
        end else begin
            cyc           <= cyc + 1;
            exp_push_cmd  <= 1'b0;
            exp_cpar      <= 1'b0;
            exp_push_data <= 1'b0;
            exp_dpar      <= 1'b0;
            if (cmd_q.size() != 0 && cmd_q[0].due == cyc) begin
                ce = cmd_q.pop_front();
                exp_push_cmd <= 1'b1;
                exp_hdr      <= ce.hdr;
                exp_class    <= ce.cls;
                exp_fc       <= ce.fc;
                exp_cpar     <= ce.par_err;
            end
            if (data_q.size() != 0 && data_q[0].due == cyc) begin
                de = data_q.pop_front();
                exp_push_data <= 1'b1;
                exp_data      <= de.data;
                exp_data_fc   <= de.fc;
                exp_offset    <= de.offset;
                exp_dpar      <= de.par_err;
            end
            exp_pending <= (cmd_q.size() != 0) || (data_q.size() != 0);
        end
    end

    always @(negedge prim_nonflr_clk) begin
        if (push_cmd) begin
            seen_cmds++;
        end
        if (push_data) begin
            seen_beats++;
        end
    end

    a_push_cmd: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        push_cmd == exp_push_cmd)
        else report_mismatch("push_cmd", DATA_W'($sampled(push_cmd)),
                             DATA_W'($sampled(exp_push_cmd)));
    a_cmd_hdr: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        exp_push_cmd |-> cmd_hdr == exp_hdr)
        else report_mismatch("cmd_hdr", DATA_W'($sampled(cmd_hdr)), DATA_W'($sampled(exp_hdr)));
    a_cmd_class: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        exp_push_cmd |-> cmd_class == exp_class)
        else report_mismatch("cmd_class", DATA_W'($sampled(cmd_class)),
                             DATA_W'($sampled(exp_class)));
    a_cmd_fc: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        exp_push_cmd |-> cmd_fc == exp_fc)
        else report_mismatch("cmd_fc", DATA_W'($sampled(cmd_fc)), DATA_W'($sampled(exp_fc)));
    a_cpar: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        cpar_err == (exp_push_cmd && exp_cpar))
        else report_mismatch("cpar_err", DATA_W'($sampled(cpar_err)),
                             DATA_W'($sampled(exp_push_cmd && exp_cpar)));
    a_push_data: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        push_data == exp_push_data)
        else report_mismatch("push_data", DATA_W'($sampled(push_data)),
                             DATA_W'($sampled(exp_push_data)));
    a_data_out: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        exp_push_data |-> data_out == exp_data)
        else report_mismatch("data_out", $sampled(data_out), $sampled(exp_data));
    a_data_fc: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        exp_push_data |-> data_fc == exp_data_fc)
        else report_mismatch("data_fc", DATA_W'($sampled(data_fc)),
                             DATA_W'($sampled(exp_data_fc)));
    a_offset: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        exp_push_data |-> data_ptr_offset == exp_offset)
        else report_mismatch("data_ptr_offset", DATA_W'($sampled(data_ptr_offset)),
                             DATA_W'($sampled(exp_offset)));
    a_dpar: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        dpar_err == (exp_push_data && exp_dpar))
        else report_mismatch("dpar_err", DATA_W'($sampled(dpar_err)),
                             DATA_W'($sampled(exp_push_data && exp_dpar)));

    // Idle drops for credit init, a put, or a push, and comes back once quiet
    a_idle_credit: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        credit_init_in_progress |-> !tgt_idle)
        else report_mismatch("tgt_idle", DATA_W'($sampled(tgt_idle)), '0);
    a_idle_put: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        cmd_put |-> !tgt_idle)
        else report_mismatch("tgt_idle", DATA_W'($sampled(tgt_idle)), '0);
    a_idle_push: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        (exp_push_cmd || exp_push_data) |-> !tgt_idle)
        else report_mismatch("tgt_idle", DATA_W'($sampled(tgt_idle)), '0);
    a_idle_quiet: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        (!credit_init_in_progress && !cmd_put && !exp_push_cmd && !exp_push_data &&
         !exp_pending) |-> tgt_idle)
        else report_mismatch("tgt_idle", DATA_W'($sampled(tgt_idle)), DATA_W'(1));

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        int len;
        int i;
        void'($urandom(95));
        prim_gated_rst_b = 1'b0;
        credit_init_in_progress = 1'b1;
        cmd_put = 1'b0;
        cmd_rtype = '0;
        cmd_fmt = '0;
        cmd_type = '0;
        cmd_length = '0;
        cmd_rqid = '0;
        cmd_tag = '0;
        cmd_address = '0;
        cmd_parity = 1'b0;
        ism_state = ISM_ACTIVE;
        data = '0;
        data_parity = 1'b0;
        repeat (3) @(posedge prim_nonflr_clk);
        prim_gated_rst_b <= 1'b1;
        // Credit init still running after reset
        repeat (4) @(posedge prim_nonflr_clk);
        credit_init_in_progress <= 1'b0;
        repeat (2) @(posedge prim_nonflr_clk);

        // Header layout and command parity over all three classes
        for (i = 0; i < N_HDR_CMDS; i++) begin
            len = 1 + int'($urandom() % 64);
            run_cmd(i % 3, 1'($urandom()), len, (i % 4) == 3, -1, 1'b0, 1'b0);
        end
        // Data phase over every length with some bad parity beats
        for (len = 1; len <= 64; len++) begin
            run_cmd(int'($urandom() % 2), 1'b1, len, 1'b0,
                    (len % 5 == 0) ? int'($urandom() % ((len + 3) / 4)) : -1, 1'b0, 1'b0);
        end
        // Puts outside ACTIVE and IDLE_REQ
        for (i = 0; i < N_GATED; i++) begin
            run_cmd(int'($urandom() % 3), 1'($urandom()), 8, 1'b0, -1, 1'b1, 1'b0);
        end
        // Next put on the last beat of the previous command
        for (i = 0; i < N_CHAIN; i++) begin
            run_cmd(int'($urandom() % 2), 1'b1, 1 + int'($urandom() % 64), 1'b0, -1, 1'b0, 1'b1);
            run_cmd(int'($urandom() % 3), 1'b1, 1 + int'($urandom() % 64), 1'b0, 0, 1'b0, 1'b0);
        end
        run_cmd(0, 1'b1, 5, 1'b0, 1, 1'b0, 1'b1);
        run_cmd(1, 1'b1, 4, 1'b0, -1, 1'b0, 1'b1);
        run_cmd(2, 1'b1, 12, 1'b1, -1, 1'b0, 1'b0);

        // Let every queued push come out and the target settle
        while (cmd_q.size() != 0 || data_q.size() != 0 || !tgt_idle) begin
            @(negedge prim_nonflr_clk);
        end
        repeat (3) @(posedge prim_nonflr_clk);
        if (seen_cmds != issued_cmds) begin
            other_errs++;
            $display("Saw %0d command pushes, but %0d commands were accepted",
                     seen_cmds, issued_cmds);
        end
        if (seen_beats != issued_beats) begin
            other_errs++;
            $display("Saw %0d data pushes, but %0d beats were sent", seen_beats, issued_beats);
        end
        $display("Summary: %0d value errors, %0d other errors, %0d commands, %0d beats",
                 value_errs, other_errs, issued_cmds, issued_beats);
        if (value_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- sim.f
source/tgt_pkg.sv
source/tgt_cmd_if.sv
source/tgt_data_if.sv
source/tgt_hdr_decode.sv
source/tgt_data_track.sv
source/tgt_queue_push.sv
source/tgt_cntrl_top.sv
verif/tb_tgt_cntrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_tgt_cntrl -f sim.f -o tb_tgt_cntrl_sim
./obj_dir/tb_tgt_cntrl_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation done"
